// ==== pipe_consts.svh ====
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// General purpose register address width.
`define REG_ADDR_W 5

// Execute stage ALU operation code width.
`define ALU_OP_W 6

// Width of each stall profiler counter. Counters wrap on overflow.
`define STALL_CNT_W 32

`endif

// ==== isa_pkg.sv ====
`default_nettype none
`include "pipe_consts.svh"

package isa_pkg;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } r_form_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } i_form_t;

    // One decode-slot word, read by format.
    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_t;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;

    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_NOP  = 6'h00,
        ALU_ADD  = 6'h01,
        ALU_SUB  = 6'h02,
        ALU_AND  = 6'h03,
        ALU_OR   = 6'h04,
        ALU_XOR  = 6'h05,
        ALU_SLT  = 6'h06,
        ALU_SLL  = 6'h07,
        ALU_SRL  = 6'h08,
        ALU_LUI  = 6'h09,
        ALU_MFC0 = 6'h1e,
        ALU_MTC0 = 6'h1f
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_type_t;

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // Stall causes seen by the profiler.
    // The encoding doubles as the counter index and the readout select.
    typedef enum logic [1:0] {
        CAUSE_ICACHE   = 2'd0,
        CAUSE_MEM      = 2'd1,
        CAUSE_EX       = 2'd2,
        CAUSE_LOAD_USE = 2'd3
    } stall_cause_t;

    localparam int NUM_CAUSES = 4;

endpackage

`default_nettype wire

// ==== hazard_detect.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module hazard_detect
    import isa_pkg::*;
(
    input  instr_t                 id_instr,
    input  instr_t                 id_instr_slave,
    input  alu_op_t                id_ex_alu_op,
    input  mem_type_t              id_ex_mem_type,
    input  logic [`REG_ADDR_W-1:0] id_ex_dest,
    input  logic                   ex_mem_cp0_wen,
    output logic                   load_use_hazard,
    output logic                   cp0_hazard
);

    //////////////////////////////////////////////////////////////////////
    // Source register decode
    //////////////////////////////////////////////////////////////////////

    // True when dest is read by the word as rs or as a live rt.
    function automatic logic reads_reg(input instr_t w, input logic [`REG_ADDR_W-1:0] dest);
        logic                   rt_live;
        logic [`REG_ADDR_W-1:0] rs_src;
        logic [`REG_ADDR_W-1:0] rt_src;
        begin
            rs_src = w.i.rs;
            rt_src = w.i.rt;
            if (w.r.opcode == OP_SPECIAL) begin
                rt_live = 1'b1;
            end else begin
                case (w.i.opcode)
                    OP_BEQ, OP_BNE:     rt_live = 1'b1; // Branch compares rs with rt.
                    OP_SW, OP_SB, OP_SH: rt_live = 1'b1; // Store data comes from rt.
                    default:            rt_live = 1'b0; // rt is the destination.
                endcase
            end
            reads_reg = (dest == rs_src) || (rt_live && (dest == rt_src));
        end
    endfunction

    logic ex_is_load;
    logic ex_dest_live;
    logic master_hit;
    logic slave_hit;
    logic ex_is_mfc0;

    assign ex_is_load   = (id_ex_mem_type == MEM_LOAD);
    assign ex_dest_live = (id_ex_dest != '0);            // r0 never carries a dependency.

    assign master_hit = reads_reg(id_instr, id_ex_dest);
    assign slave_hit  = reads_reg(id_instr_slave, id_ex_dest);

    //////////////////////////////////////////////////////////////////////
    // Hazard flags
    //////////////////////////////////////////////////////////////////////

    assign load_use_hazard = ex_is_load && ex_dest_live && (master_hit || slave_hit);

    // MFC0 in execute would read CP0 before the write in memory lands.
    assign ex_is_mfc0 = (id_ex_alu_op == ALU_MFC0);
    assign cp0_hazard = ex_is_mfc0 && ex_mem_cp0_wen;

endmodule

`default_nettype wire

// ==== pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic icache_stall,
    input  logic ex_stall,
    input  logic mem_stall,
    input  logic id_branch_taken,
    input  logic exp_detect,
    input  logic load_use_hazard,
    input  logic cp0_hazard,
    output logic en_if,
    output logic en_if_id,
    output logic en_id_ex,
    output logic en_ex_mem,
    output logic en_mem_wb,
    output logic load_use_stall
);

    logic [4:0] en;

    assign {en_if, en_if_id, en_id_ex, en_ex_mem, en_mem_wb} = en;

    //////////////////////////////////////////////////////////////////////
    // Fixed priority chain where the first match wins
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        en             = 5'b11111;
        load_use_stall = 1'b0;
        if (rst) begin
            en = 5'b11111;
        end else if (icache_stall) begin
            if (exp_detect || mem_stall) begin
                en = 5'b00000;                      // Hold everything.
            end else begin
                en = 5'b00001;                      // Let writeback drain.
            end
        end else if (mem_stall) begin
            if (id_branch_taken) begin
                en = 5'b00000;                      // Keep the branch target.
            end else begin
                en = 5'b10000;
            end
        end else if (ex_stall) begin
            en = 5'b10001;
        end else if (cp0_hazard) begin
            en = 5'b10011;                          // Bubble into execute.
        end else if (load_use_hazard) begin
            en             = 5'b10011;
            load_use_stall = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // IF/ID never takes a new word while fetch is held.
    a_if_id_needs_if: assert property (@(posedge clk) disable iff (rst)
        en_if_id |-> en_if)
        else $error("IF/ID enabled with IF held, en %b", en);

endmodule

`default_nettype wire

// ==== stall_profiler.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module stall_profiler
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    icache_stall,
    input  logic                    mem_stall,
    input  logic                    ex_stall,
    input  logic                    load_use_stall,
    input  stall_cause_t            perf_sel,
    output logic [`STALL_CNT_W-1:0] perf_count
);

    logic [NUM_CAUSES-1:0]   cause_hit;
    logic [`STALL_CNT_W-1:0] cnt [NUM_CAUSES];

    always_comb begin
        cause_hit                 = '0;
        cause_hit[CAUSE_ICACHE]   = icache_stall;
        cause_hit[CAUSE_MEM]      = mem_stall;
        cause_hit[CAUSE_EX]       = ex_stall;
        cause_hit[CAUSE_LOAD_USE] = load_use_stall; // Only when the load-use case won.
    end

    //////////////////////////////////////////////////////////////////////
    // Per-cause counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CAUSES; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CAUSES; i++) begin
                if (cause_hit[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;        // Wraps at full scale.
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Readout
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            perf_count <= '0;
        end else begin
            perf_count <= cnt[perf_sel];
        end
    end

    // Counters only move by one per cycle, so a select held steady
    // never reads a value that went backwards other than a wrap.
    a_count_monotonic: assert property (@(posedge clk) disable iff (rst)
        $stable(perf_sel) && !$past(rst) |=>
            (perf_count - $past(perf_count)) <= `STALL_CNT_W'(1))
        else $error("perf_count jumped from %h to %h", $past(perf_count), perf_count);

endmodule

`default_nettype wire

// ==== stall_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module stall_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    // External stall levels.
    input  logic                    icache_stall,
    input  logic                    ex_stall,
    input  logic                    mem_stall,

    // Instruction in execute.
    input  alu_op_t                 id_ex_alu_op,
    input  mem_type_t               id_ex_mem_type,
    input  logic [`REG_ADDR_W-1:0]  id_ex_dest,
    input  logic                    ex_mem_cp0_wen,

    // Decode slots.
    input  instr_t                  id_instr,
    input  instr_t                  id_instr_slave,
    input  logic                    id_branch_taken,
    input  logic                    exp_detect,

    // Stage enables.
    output logic                    en_if,
    output logic                    en_if_id,
    output logic                    en_id_ex,
    output logic                    en_ex_mem,
    output logic                    en_mem_wb,

    // Profiler readout.
    input  stall_cause_t            perf_sel,
    output logic [`STALL_CNT_W-1:0] perf_count
);

    logic load_use_hazard;
    logic cp0_hazard;
    logic load_use_stall;

    //////////////////////////////////////////////////////////////////////
    // Hazard detection, then enable priority, then profiling
    //////////////////////////////////////////////////////////////////////

    hazard_detect hazard_detect_i (
        .id_instr        (id_instr),
        .id_instr_slave  (id_instr_slave),
        .id_ex_alu_op    (id_ex_alu_op),
        .id_ex_mem_type  (id_ex_mem_type),
        .id_ex_dest      (id_ex_dest),
        .ex_mem_cp0_wen  (ex_mem_cp0_wen),
        .load_use_hazard (load_use_hazard),
        .cp0_hazard      (cp0_hazard)
    );

    pipe_ctrl pipe_ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .icache_stall    (icache_stall),
        .ex_stall        (ex_stall),
        .mem_stall       (mem_stall),
        .id_branch_taken (id_branch_taken),
        .exp_detect      (exp_detect),
        .load_use_hazard (load_use_hazard),
        .cp0_hazard      (cp0_hazard),
        .en_if           (en_if),
        .en_if_id        (en_if_id),
        .en_id_ex        (en_id_ex),
        .en_ex_mem       (en_ex_mem),
        .en_mem_wb       (en_mem_wb),
        .load_use_stall  (load_use_stall)
    );

    stall_profiler stall_profiler_i (
        .clk             (clk),
        .rst             (rst),
        .icache_stall    (icache_stall),
        .mem_stall       (mem_stall),
        .ex_stall        (ex_stall),
        .load_use_stall  (load_use_stall),
        .perf_sel        (perf_sel),
        .perf_count      (perf_count)
    );

endmodule

`default_nettype wire

// ==== tb_stall_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module tb_stall_unit
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int RAND_CYCLES = 2000;
    localparam int CYCLE_LIMIT = 3000;           // Random traffic plus directed cases and margin.

    localparam logic [5:0] OP_LW   = 6'h23;      // Non-store I-form that writes rt.
    localparam logic [5:0] OP_ADDI = 6'h08;

    logic                    clk;
    logic                    rst;
    logic                    icache_stall;
    logic                    ex_stall;
    logic                    mem_stall;
    alu_op_t                 id_ex_alu_op;
    mem_type_t               id_ex_mem_type;
    logic [`REG_ADDR_W-1:0]  id_ex_dest;
    logic                    ex_mem_cp0_wen;
    instr_t                  id_instr;
    instr_t                  id_instr_slave;
    logic                    id_branch_taken;
    logic                    exp_detect;
    stall_cause_t            perf_sel;
    logic                    en_if;
    logic                    en_if_id;
    logic                    en_id_ex;
    logic                    en_ex_mem;
    logic                    en_mem_wb;
    logic [`STALL_CNT_W-1:0] perf_count;

    logic [31:0]             lfsr;
    int                      cycle_count;

    stall_unit dut_i (.*);

    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic uses_as_source(input logic [31:0] w,
                                            input logic [`REG_ADDR_W-1:0] r);
        logic [5:0] op;
        logic       rt_read;
        begin
            op      = w[31:26];
            rt_read = (op == OP_SPECIAL) || (op == OP_BEQ) || (op == OP_BNE) ||
                      (op == OP_SW) || (op == OP_SB) || (op == OP_SH);
            uses_as_source = (w[25:21] == r) || (rt_read && (w[20:16] == r));
        end
    endfunction

    logic                    exp_lu_hazard;
    logic                    exp_cp0_hazard;
    logic                    exp_lu_stall;
    logic [4:0]              exp_en;
    logic [4:0]              dut_en;
    logic [`STALL_CNT_W-1:0] model_cnt [4];
    logic [`STALL_CNT_W-1:0] model_perf;

    assign exp_lu_hazard = (id_ex_mem_type == MEM_LOAD) && (id_ex_dest != '0) &&
        (uses_as_source(id_instr, id_ex_dest) || uses_as_source(id_instr_slave, id_ex_dest));
    assign exp_cp0_hazard = (id_ex_alu_op == ALU_MFC0) && ex_mem_cp0_wen;
    assign dut_en = {en_if, en_if_id, en_id_ex, en_ex_mem, en_mem_wb};

    always_comb begin
        exp_en       = 5'b11111;
        exp_lu_stall = 1'b0;
        if (rst) exp_en = 5'b11111;
        else if (icache_stall && (exp_detect || mem_stall)) exp_en = 5'b00000;
        else if (icache_stall) exp_en = 5'b00001;
        else if (mem_stall && id_branch_taken) exp_en = 5'b00000;
        else if (mem_stall) exp_en = 5'b10000;
        else if (ex_stall) exp_en = 5'b10001;
        else if (exp_cp0_hazard) exp_en = 5'b10011;
        else if (exp_lu_hazard) begin
            exp_en       = 5'b10011;
            exp_lu_stall = 1'b1;                 // Counted only when it wins.
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            model_cnt[CAUSE_ICACHE]   <= '0;
            model_cnt[CAUSE_MEM]      <= '0;
            model_cnt[CAUSE_EX]       <= '0;
            model_cnt[CAUSE_LOAD_USE] <= '0;
            model_perf                <= '0;
        end else begin
            if (icache_stall) model_cnt[CAUSE_ICACHE] <= model_cnt[CAUSE_ICACHE] + 1'b1;
            if (mem_stall) model_cnt[CAUSE_MEM] <= model_cnt[CAUSE_MEM] + 1'b1;
            if (ex_stall) model_cnt[CAUSE_EX] <= model_cnt[CAUSE_EX] + 1'b1;
            if (exp_lu_stall) model_cnt[CAUSE_LOAD_USE] <= model_cnt[CAUSE_LOAD_USE] + 1'b1;
            model_perf <= model_cnt[perf_sel];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        stop_on_failure("DUT output differs from the model");
    endtask

    a_enables: assert property (@(posedge clk) dut_en == exp_en)
        else report_mismatch("en_if..en_mem_wb", {27'b0, $sampled(dut_en)},
                             {27'b0, $sampled(exp_en)});

    a_perf_count: assert property (@(posedge clk) disable iff (rst) perf_count == model_perf)
        else report_mismatch("perf_count", $sampled(perf_count), $sampled(model_perf));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            stop_on_failure("timeout, the test did not finish within the cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        galois_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        int          k;
        logic [31:0] v;
        begin
            v = '0;
            for (k = 0; k < n; k++) begin
                lfsr = galois_step(lfsr);
                v    = {v[30:0], lfsr[0]};
            end
            take_bits = v;
        end
    endfunction

    function automatic logic [5:0] pick_opcode(input logic [2:0] k);
        case (k)
            3'd0:    pick_opcode = OP_SPECIAL;
            3'd1:    pick_opcode = OP_BEQ;
            3'd2:    pick_opcode = OP_BNE;
            3'd3:    pick_opcode = OP_SW;
            3'd4:    pick_opcode = OP_SB;
            3'd5:    pick_opcode = OP_SH;
            3'd6:    pick_opcode = OP_LW;
            default: pick_opcode = OP_ADDI;
        endcase
    endfunction

    function automatic logic [31:0] make_word(input logic [5:0] op,
                                              input logic [`REG_ADDR_W-1:0] rs,
                                              input logic [`REG_ADDR_W-1:0] rt);
        make_word = {op, rs, rt, 16'h0000};
    endfunction

    task automatic set_idle();
        icache_stall    <= 1'b0;
        ex_stall        <= 1'b0;
        mem_stall       <= 1'b0;
        id_branch_taken <= 1'b0;
        exp_detect      <= 1'b0;
        id_ex_alu_op    <= ALU_NOP;
        id_ex_mem_type  <= MEM_NONE;
        id_ex_dest      <= '0;
        ex_mem_cp0_wen  <= 1'b0;
        id_instr        <= '0;
        id_instr_slave  <= '0;
    endtask

    task automatic stall_cycle(input logic ic, input logic mm, input logic ex,
                               input logic br, input logic exc);
        @(posedge clk);
        set_idle();
        icache_stall    <= ic;
        mem_stall       <= mm;
        ex_stall        <= ex;
        id_branch_taken <= br;
        exp_detect      <= exc;
    endtask

    task automatic hazard_cycle(input mem_type_t mt, input logic [`REG_ADDR_W-1:0] dest,
                                input logic [31:0] m, input logic [31:0] s);
        @(posedge clk);
        set_idle();
        id_ex_mem_type <= mt;
        id_ex_dest     <= dest;
        id_instr       <= m;
        id_instr_slave <= s;
    endtask

    task automatic cp0_cycle(input alu_op_t op, input logic wen);
        @(posedge clk);
        set_idle();
        id_ex_alu_op   <= op;
        ex_mem_cp0_wen <= wen;
    endtask

    task automatic random_cycle();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] m;
        logic [31:0] s;
        begin
            a = take_bits(13);
            b = take_bits(23);
            c = take_bits(23);
            m = {pick_opcode(b[2:0]), 3'b000, b[4:3], 3'b000, b[6:5], b[22:7]};
            s = {pick_opcode(c[2:0]), 3'b000, c[4:3], 3'b000, c[6:5], c[22:7]};
            @(posedge clk);
            icache_stall    <= a[0] & a[1];      // Two bits per stall keep them rare.
            mem_stall       <= a[2] & a[3];
            ex_stall        <= a[4] & a[5];
            id_branch_taken <= a[6];
            exp_detect      <= a[7];
            id_ex_alu_op    <= (a[8] & a[9]) ? ALU_MFC0 : ALU_ADD;
            ex_mem_cp0_wen  <= a[10];
            id_ex_mem_type  <= (a[12:11] == 2'd0) ? MEM_NONE :
                               (a[12:11] == 2'd2) ? MEM_STORE : MEM_LOAD;
            id_ex_dest      <= {3'b000, b[6:5] ^ c[4:3]};
            id_instr        <= m;
            id_instr_slave  <= s;
            perf_sel        <= stall_cause_t'(a[12:11] ^ b[1:0]);
        end
    endtask

    initial begin
        int i;
        clk            = 1'b0;
        rst            = 1'b1;
        lfsr           = 32'h964d;
        cycle_count    = 0;
        perf_sel       = CAUSE_ICACHE;
        icache_stall   = 1'b0;
        ex_stall       = 1'b0;
        mem_stall      = 1'b0;
        id_ex_alu_op   = ALU_NOP;
        id_ex_mem_type = MEM_NONE;
        id_ex_dest     = '0;
        ex_mem_cp0_wen = 1'b0;
        id_instr       = '0;
        id_instr_slave = '0;
        id_branch_taken = 1'b0;
        exp_detect     = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (i = 0; i < 4; i++) begin            // Idle readout of every cause.
            @(posedge clk);
            perf_sel <= stall_cause_t'(i);
        end

        stall_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        stall_cycle(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        stall_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        stall_cycle(1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
        stall_cycle(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        stall_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        stall_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
        stall_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        stall_cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b1);

        hazard_cycle(MEM_LOAD, 5'd3, make_word(OP_SPECIAL, 5'd3, 5'd0), '0);
        hazard_cycle(MEM_LOAD, 5'd3, make_word(OP_SPECIAL, 5'd1, 5'd3), '0);
        hazard_cycle(MEM_LOAD, 5'd3, '0, make_word(OP_SW, 5'd1, 5'd3));
        hazard_cycle(MEM_LOAD, 5'd3, '0, make_word(OP_BNE, 5'd1, 5'd3));
        hazard_cycle(MEM_LOAD, 5'd3, '0, make_word(OP_SB, 5'd3, 5'd1));
        hazard_cycle(MEM_LOAD, 5'd0, make_word(OP_SPECIAL, 5'd0, 5'd0), '0);
        hazard_cycle(MEM_LOAD, 5'd3, make_word(OP_ADDI, 5'd1, 5'd3), '0);
        hazard_cycle(MEM_STORE, 5'd3, make_word(OP_SPECIAL, 5'd3, 5'd3), '0);
        hazard_cycle(MEM_LOAD, 5'd3, make_word(OP_BEQ, 5'd2, 5'd3), '0);
        ex_stall <= 1'b1;                        // Execute stall beats load-use.

        cp0_cycle(ALU_MFC0, 1'b1);
        cp0_cycle(ALU_MFC0, 1'b0);
        cp0_cycle(ALU_MTC0, 1'b1);
        cp0_cycle(ALU_MFC0, 1'b1);
        mem_stall <= 1'b1;

        repeat (RAND_CYCLES) random_cycle();

        @(posedge clk);
        set_idle();
        for (i = 0; i < 4; i++) begin            // Final per-cause counts.
            @(posedge clk);
            perf_sel <= stall_cause_t'(i);
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
hazard_detect.sv
pipe_ctrl.sv
stall_profiler.sv
stall_unit.sv
tb_stall_unit.sv

// ==== run.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass message.
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_stall_unit -o sim_stall_unit \
    && ./obj_dir/sim_stall_unit | tee /dev/stderr | grep -q "test passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
